// ==== rbm.f ====
verilog/rbm_pkg.sv
verilog/rbm_stream_loader.sv
verilog/rbm_energy_accum.sv
verilog/rbm_hidden_out.sv
verilog/rbm_top.sv
tb/rbm_asserts.sv
tb/rbm_tb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module rbm_tb -f rbm.f -o rbm_sim

status=0
./obj_dir/rbm_sim > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "Errors found" sim.log || [ "$status" -ne 0 ]; then
  echo "simulation failed"
  exit 1
fi
echo "simulation passed"

// ==== tb/rbm_asserts.sv ====
`timescale 1ns/1ps

module rbm_asserts import rbm_pkg::*; (
  input logic          clk,
  input logic          rst,
  input logic          vec_valid,
  input logic          hid_valid,
  input logic          data_out_valid,
  input logic          data_out_ready,
  input word_t         data_out_data,
  input loader_state_t loader_state
);

  // a stalled output word holds still
  assert property (@(posedge clk) disable iff (rst)
    data_out_valid && !data_out_ready |=> data_out_valid && $stable(data_out_data))
    else $error("data_out changed while data_out_ready was low");

  assert property (@(posedge clk)
    rst |=> !vec_valid && !hid_valid && !data_out_valid)
    else $error("valid high in the cycle after reset");

  // no result before the weights are in
  assert property (@(posedge clk) disable iff (rst)
    $rose(hid_valid) |-> loader_state == run)
    else $error("hid_valid rose while the loader was loading weights");

endmodule

bind rbm_top rbm_asserts u_asserts (
  .clk            (clk),
  .rst            (rst),
  .vec_valid      (vec_valid),
  .hid_valid      (hid_valid),
  .data_out_valid (data_out_valid),
  .data_out_ready (data_out_ready),
  .data_out_data  (data_out_data),
  .loader_state   (u_loader.state)
);

// ==== tb/rbm_cases.txt ====
# C nv nh = configuration, decimal | W row = hex weights of one hidden unit, byte v is visible v
# V vector expected = visible vector and expected hidden word, both hex
C 16 8
W 01010101010101010101010101010101
W ffffffffffffffffffffffffffffffff
W fefefefefefefefe0202020202020202
W fd03fd03fd03fd03fd03fd03fd03fd03
W 8080808080808080808080808080807f
W 10ffffffffffffffffffffffffffffff
W 00000000000000000000000000000000
W 0000000000000000000000000000fb05
V 0000 00
V ffff 21
V 0001 9d
V 8000 21
V 00ff 05
V 5555 89
V aaaa 21
V 0102 01
C 5 3
W 0504030201
W 01010101fc
W 00fd03fd03
V ffe0 00
V ffff 01
V fffe 03
V 0005 05
V aa14 07
C 5 3
W ffffffffff
W ffffffff04
W 0003fd03fd
V ffff 00
V 0005 02
V 000a 04
V 0001 02

// ==== tb/rbm_tb.sv ====
`timescale 1ns/1ps

module rbm_tb import rbm_pkg::*; ();

  localparam int period = 100;
  localparam int seed   = 34350;
  localparam cases_file = "tb/rbm_cases.txt";

  logic  clk = 1'b0;
  logic  rst;
  logic  conf_done;
  word_t conf_num_visible;
  word_t conf_num_hidden;
  word_t data_in_data;
  logic  data_in_valid;
  logic  data_in_ready;
  word_t data_out_data;
  logic  data_out_valid;
  logic  data_out_ready = 1'b0;

  // parsed case records, in file order
  logic [7:0]   kinds[$];
  logic [127:0] args_a[$];
  word_t        args_b[$];
  word_t        exp_q[$];
  int           n_recs = 0;
  int           tests  = 0;
  int           errors = 0;
  int           cur_nv = 1;

  rbm_top UUT (
    .clk              (clk),
    .rst              (rst),
    .conf_done        (conf_done),
    .conf_num_visible (conf_num_visible),
    .conf_num_hidden  (conf_num_hidden),
    .data_in_data     (data_in_data),
    .data_in_valid    (data_in_valid),
    .data_in_ready    (data_in_ready),
    .data_out_data    (data_out_data),
    .data_out_valid   (data_out_valid),
    .data_out_ready   (data_out_ready)
  );

  always #(period / 2) clk = ~clk;

  // output stalls about a quarter of the time
  always @(negedge clk) begin
    if (rst) begin
      data_out_ready = 1'b0;
    end else begin
      data_out_ready = ($urandom % 4) != 0;
    end
  end

  task automatic compare_word(input string name, input word_t got, input word_t exp);
    tests++;
    if (got !== exp) begin
      errors++;
      $display("[FAIL] test %0d %s: got %h, expected %h", tests, name, got, exp);
    end else begin
      $display("[ok] test %0d %s = %h", tests, name, got);
    end
  endtask

  task automatic read_cases(output bit ok);
    int           fd;
    int           cnt;
    int           want;
    string        line;
    logic [127:0] a;
    word_t        b;
    ok = 1'b0;
    fd = $fopen(cases_file, "r");
    if (fd != 0) begin
      ok = 1'b1;
      while ($fgets(line, fd) != 0) begin
        a    = '0;
        b    = '0;
        want = 0;
        case (line[0])
          "C": begin
            want = 2;
            cnt  = $sscanf(line, "C %d %d", a, b);
          end
          "W": begin
            want = 1;
            cnt  = $sscanf(line, "W %h", a);
          end
          "V": begin
            want = 2;
            cnt  = $sscanf(line, "V %h %h", a, b);
          end
          default: cnt = 0;
        endcase
        if (cnt != want) begin
          $display("malformed line in the cases file: %s", line);
          ok = 1'b0;
        end else if (want != 0) begin
          kinds.push_back(line[0]);
          args_a.push_back(a);
          args_b.push_back(b);
        end
      end
      $fclose(fd);
      n_recs = kinds.size();
    end
  endtask

  // called at a falling edge, returns at the falling edge after the transfer
  task automatic send_word(input word_t w);
    if ($urandom % 4 == 0) begin
      data_in_valid = 1'b0;
      @(negedge clk);
    end
    data_in_data  = w;
    data_in_valid = 1'b1;
    while (!data_in_ready) @(negedge clk);
    @(negedge clk);
    data_in_valid = 1'b0;
  endtask

  task automatic wait_drain();
    while (exp_q.size() != 0) @(negedge clk);
  endtask

  // results come back in vector order
  always @(posedge clk) begin
    if (!rst && data_out_valid && data_out_ready) begin
      if (exp_q.size() == 0) begin
        errors++;
        $display("an output word %h arrived with no vector pending", data_out_data);
      end else begin
        compare_word("data_out_data", data_out_data, exp_q.pop_front());
      end
    end
  end

  initial begin
    wait (n_recs > 0);
    #(n_recs * (edge_depth + 40) * period);
    $display("timeout: the run did not finish within %0d cycles", n_recs * (edge_depth + 40));
    $display("Errors found");
    $finish;
  end

  initial begin
    bit           ok;
    logic [127:0] row;
    rst              = 1'b1;
    conf_done        = 1'b0;
    conf_num_visible = '0;
    conf_num_hidden  = '0;
    data_in_data     = '0;
    data_in_valid    = 1'b0;
    void'($urandom(seed));
    read_cases(ok);
    if (!ok || n_recs == 0) begin
      $display("the cases file could not be read");
      $display("Errors found");
      $finish;
    end else begin
      repeat (5) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;
      for (int i = 0; i < n_recs; i++) begin
        case (kinds[i])
          "C": begin
            // reconfigure only with the pipeline empty
            wait_drain();
            conf_num_visible = word_t'(args_a[i]);
            conf_num_hidden  = args_b[i];
            conf_done        = 1'b1;
            @(negedge clk);
            conf_done = 1'b0;
            cur_nv    = int'(args_a[i]);
          end
          "W": begin
            row = args_a[i];
            for (int v = 0; v < cur_nv; v++) begin
              send_word(word_t'(row[8*v +: 8]));
            end
          end
          default: begin
            exp_q.push_back(args_b[i]);
            send_word(word_t'(args_a[i]));
          end
        endcase
      end
      wait_drain();
      repeat (4) @(negedge clk);
      $display("%0d tests, %0d errors", tests, errors);
      if (errors == 0) begin
        $display("No errors");
      end else begin
        $display("Errors found");
      end
      $finish;
    end
  end

endmodule

// ==== verilog/rbm_energy_accum.sv ====
`timescale 1ns/1ps

module rbm_energy_accum import rbm_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  logic       edge_wr_en,
  input  edge_addr_t edge_wr_addr,
  input  weight_t    edge_wr_data,
  input  logic       vec_valid,
  input  visible_t   vec_data,
  input  vis_count_t nv,
  input  hid_count_t nh,
  input  logic       hid_ready,
  output logic       vec_ready,
  output logic       hid_valid,
  output hidden_t    hid_data
);

  weight_t      edge_mem [edge_depth];
  accum_state_t state;
  visible_t     vec_reg;
  hidden_t      hid_reg;
  vis_count_t   cnt_v;
  hid_count_t   cnt_h;
  logic         row_end;

  // read pipeline stage
  weight_t      rd_q;
  logic         rd_vld;
  logic         rd_bit;
  logic         rd_last;
  hid_count_t   rd_h;

  energy_t      acc;
  energy_t      sum;

  assign row_end   = (cnt_v == nv - 1'b1);
  assign vec_ready = (state == idle);
  // hold starts with the last read still in flight
  assign hid_valid = (state == hold) && !rd_vld;
  assign hid_data  = hid_reg;

  assign sum = acc + (rd_bit ? energy_t'(rd_q) : energy_t'(0));

  always_ff @(posedge clk) begin
    if (edge_wr_en) begin
      edge_mem[edge_wr_addr] <= edge_wr_data;
    end
    rd_q    <= edge_mem[edge_addr(cnt_h, cnt_v)];
    rd_bit  <= vec_reg[cnt_v[$clog2(max_visible)-1:0]];
    rd_last <= row_end;
    rd_h    <= cnt_h;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state  <= idle;
      cnt_v  <= '0;
      cnt_h  <= '0;
      rd_vld <= 1'b0;
      acc    <= '0;
    end else begin
      rd_vld <= (state == busy);
      case (state)
        idle: begin
          if (vec_valid) begin
            vec_reg <= vec_data;
            hid_reg <= '0;
            cnt_v   <= '0;
            cnt_h   <= '0;
            state   <= busy;
          end
        end
        busy: begin
          if (row_end) begin
            cnt_v <= '0;
            if (cnt_h == nh - 1'b1) begin
              state <= hold;
            end else begin
              cnt_h <= cnt_h + 1'b1;
            end
          end else begin
            cnt_v <= cnt_v + 1'b1;
          end
        end
        hold: begin
          if (hid_valid && hid_ready) begin
            state <= idle;
          end
        end
        default: state <= idle;
      endcase

      // strictly positive sign test at the end of each hidden row
      if (rd_vld) begin
        if (rd_last) begin
          hid_reg[rd_h[$clog2(max_hidden)-1:0]] <= (sum > 0);
          acc <= '0;
        end else begin
          acc <= sum;
        end
      end
    end
  end

endmodule

// ==== verilog/rbm_hidden_out.sv ====
`timescale 1ns/1ps

module rbm_hidden_out import rbm_pkg::*; (
  input  logic    clk,
  input  logic    rst,
  input  logic    hid_valid,
  input  hidden_t hid_data,
  input  logic    data_out_ready,
  output logic    hid_ready,
  output logic    data_out_valid,
  output word_t   data_out_data
);

  hidden_t out_reg;
  logic    out_full;

  // refill in the same cycle the old word leaves
  assign hid_ready      = !out_full || data_out_ready;
  assign data_out_valid = out_full;
  assign data_out_data  = word_t'(out_reg);

  always_ff @(posedge clk) begin
    if (hid_valid && hid_ready) begin
      out_reg <= hid_data;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      out_full <= 1'b0;
    end else if (hid_valid && hid_ready) begin
      out_full <= 1'b1;
    end else if (data_out_ready) begin
      out_full <= 1'b0;
    end
  end

endmodule

// ==== verilog/rbm_pkg.sv ====
package rbm_pkg;

  // array limits
  localparam int max_visible = 16;
  localparam int max_hidden  = 8;
  localparam int edge_depth  = max_visible * max_hidden;

  typedef logic        [31:0]                         word_t;
  typedef logic signed [7:0]                          weight_t;
  typedef logic        [$clog2(edge_depth)-1:0]       edge_addr_t;
  typedef logic        [max_visible-1:0]              visible_t;
  typedef logic        [max_hidden-1:0]               hidden_t;
  typedef logic signed [15:0]                         energy_t;
  typedef logic        [$clog2(max_visible+1)-1:0]    vis_count_t;
  typedef logic        [$clog2(max_hidden+1)-1:0]     hid_count_t;

  typedef enum logic {
    load_weights,
    run
  } loader_state_t;

  typedef enum logic [1:0] {
    idle,
    busy,
    hold
  } accum_state_t;

  // hidden-major edge layout
  function automatic edge_addr_t edge_addr(hid_count_t h, vis_count_t v);
    return edge_addr_t'(h * max_visible + v);
  endfunction

endpackage

// ==== verilog/rbm_stream_loader.sv ====
`timescale 1ns/1ps

module rbm_stream_loader import rbm_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  logic       conf_done,
  input  word_t      conf_num_visible,
  input  word_t      conf_num_hidden,
  input  word_t      data_in_data,
  input  logic       data_in_valid,
  input  logic       vec_ready,
  output logic       data_in_ready,
  output logic       edge_wr_en,
  output edge_addr_t edge_wr_addr,
  output weight_t    edge_wr_data,
  output logic       vec_valid,
  output visible_t   vec_data,
  output vis_count_t nv,
  output hid_count_t nh
);

  loader_state_t state;
  vis_count_t    wv;
  hid_count_t    wh;
  logic          wt_take;
  logic          row_end;
  logic          last_wt;
  visible_t      vis_mask;

  // weights are always accepted, vectors only when the accumulator is free
  assign data_in_ready = (state == load_weights) ? 1'b1 : vec_ready;
  assign wt_take       = (state == load_weights) && data_in_valid;
  assign row_end       = (wv == nv - 1'b1);
  assign last_wt       = row_end && (wh == nh - 1'b1);

  assign edge_wr_en   = wt_take;
  assign edge_wr_addr = edge_addr(wh, wv);
  assign edge_wr_data = weight_t'(data_in_data[$bits(weight_t)-1:0]);

  // keep only the low nv bits
  assign vis_mask  = ~(visible_t'('1) << nv);
  assign vec_valid = (state == run) && data_in_valid;
  assign vec_data  = visible_t'(data_in_data[max_visible-1:0]) & vis_mask;

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= load_weights;
      nv    <= vis_count_t'(1);
      nh    <= hid_count_t'(1);
      wv    <= '0;
      wh    <= '0;
    end else if (conf_done) begin
      state <= load_weights;
      wv    <= '0;
      wh    <= '0;
      // clamp into 1..max
      if (conf_num_visible == '0) begin
        nv <= vis_count_t'(1);
      end else if (conf_num_visible > word_t'(max_visible)) begin
        nv <= vis_count_t'(max_visible);
      end else begin
        nv <= vis_count_t'(conf_num_visible);
      end
      if (conf_num_hidden == '0) begin
        nh <= hid_count_t'(1);
      end else if (conf_num_hidden > word_t'(max_hidden)) begin
        nh <= hid_count_t'(max_hidden);
      end else begin
        nh <= hid_count_t'(conf_num_hidden);
      end
    end else if (wt_take) begin
      if (row_end) begin
        wv <= '0;
        if (last_wt) begin
          wh    <= '0;
          state <= run;
        end else begin
          wh <= wh + 1'b1;
        end
      end else begin
        wv <= wv + 1'b1;
      end
    end
  end

endmodule

// ==== verilog/rbm_top.sv ====
`timescale 1ns/1ps

module rbm_top import rbm_pkg::*; (
  input  logic  clk,
  input  logic  rst,
  input  logic  conf_done,
  input  word_t conf_num_visible,
  input  word_t conf_num_hidden,
  input  word_t data_in_data,
  input  logic  data_in_valid,
  output logic  data_in_ready,
  output word_t data_out_data,
  output logic  data_out_valid,
  input  logic  data_out_ready
);

  logic       edge_wr_en;
  edge_addr_t edge_wr_addr;
  weight_t    edge_wr_data;
  logic       vec_valid;
  logic       vec_ready;
  visible_t   vec_data;
  vis_count_t nv;
  hid_count_t nh;
  logic       hid_valid;
  logic       hid_ready;
  hidden_t    hid_data;

  rbm_stream_loader u_loader (
    .clk              (clk),
    .rst              (rst),
    .conf_done        (conf_done),
    .conf_num_visible (conf_num_visible),
    .conf_num_hidden  (conf_num_hidden),
    .data_in_data     (data_in_data),
    .data_in_valid    (data_in_valid),
    .vec_ready        (vec_ready),
    .data_in_ready    (data_in_ready),
    .edge_wr_en       (edge_wr_en),
    .edge_wr_addr     (edge_wr_addr),
    .edge_wr_data     (edge_wr_data),
    .vec_valid        (vec_valid),
    .vec_data         (vec_data),
    .nv               (nv),
    .nh               (nh)
  );

  rbm_energy_accum u_accum (
    .clk          (clk),
    .rst          (rst),
    .edge_wr_en   (edge_wr_en),
    .edge_wr_addr (edge_wr_addr),
    .edge_wr_data (edge_wr_data),
    .vec_valid    (vec_valid),
    .vec_data     (vec_data),
    .nv           (nv),
    .nh           (nh),
    .hid_ready    (hid_ready),
    .vec_ready    (vec_ready),
    .hid_valid    (hid_valid),
    .hid_data     (hid_data)
  );

  rbm_hidden_out u_out (
    .clk            (clk),
    .rst            (rst),
    .hid_valid      (hid_valid),
    .hid_data       (hid_data),
    .data_out_ready (data_out_ready),
    .hid_ready      (hid_ready),
    .data_out_valid (data_out_valid),
    .data_out_data  (data_out_data)
  );

endmodule
